/* dv/loader_tests.svh */
////////////////////////////////////////
// Directed loader tests and expected-address model
////////////////////////////////////////

`ifndef LOADER_TESTS_SVH
`define LOADER_TESTS_SVH

logic [PAGE_W-1:0] exp_page;  // Expansion page the DUT should be on
logic              exp_combo;

// Two upper-case hex characters, spare page when malformed
function automatic logic [PAGE_W-1:0] ext_first_page(input logic [15:0] ext);
	logic [PAGE_W-1:0] p;
	logic [7:0]        c;
	logic [7:0]        v;
	p = PAGE_BAD_EXT;
	for (int i = 0; i < 2; i++) begin
		c = ext[8*i +: 8];
		v = 8'hFF;
		if (c >= "0" && c <= "9")
			v = c - 8'd48;
		else if (c >= "A" && c <= "F")
			v = c - 8'd55;
		if (v != 8'hFF)
			p[4*i +: 4] = v[3:0];
	end
	if (ext == "ZZ" || ext == "Z0")
		p = '0;
	return p;
endfunction

task automatic expect_mem(input mem_wr_t w);
	exp_mem.push_back(w);
	if (w.addr[22])
		exp_map[w.addr[21:14]] = 1'b1; // High ROM page now present
endtask

task automatic expect_rom(input logic [HOST_ADDR_W-1:0] a, input logic [7:0] d);
	mem_wr_t           w;
	logic [PAGE_W-1:0] base;
	if (a[24:17] != 8'd0)
		return; // Slot 8 and up
	case (a[15:14])
		2'd0:    base = PAGE_OS;
		2'd1:    base = PAGE_BASIC;
		2'd2:    base = PAGE_AMSDOS;
		default: base = PAGE_MF2;
	endcase
	w.addr = {base, a[13:0]};
	w.bank = {1'b0, a[16]};
	w.data = d;
	expect_mem(w);
endtask

task automatic expect_ext(input logic [HOST_ADDR_W-1:0] a, input logic [7:0] d);
	mem_wr_t w;
	w.addr = {exp_page[8], exp_page[7:0] + a[21:14], a[13:0]};
	w.bank = {1'b0, exp_model};
	w.data = d;
	expect_mem(w);
	if (exp_combo && a[13:0] == 14'h3FFF) begin
		exp_page  = PAGE_COMBO_NEXT;
		exp_combo = 1'b0;
	end
endtask

task automatic compare_writes(input string name);
	if (got_mem.size() != exp_mem.size()) begin
		report_value({name, " memory write count"}, 256'(exp_mem.size()),
			256'(got_mem.size()));
	end else begin
		for (int i = mem_done; i < exp_mem.size(); i++)
			if (got_mem[i] !== exp_mem[i])
				report_value({name, " memory write"}, 256'(exp_mem[i]), 256'(got_mem[i]));
	end
	if (got_tape.size() != exp_tape.size()) begin
		report_value({name, " tape write count"}, 256'(exp_tape.size()),
			256'(got_tape.size()));
	end else begin
		for (int i = tape_done; i < exp_tape.size(); i++)
			if (got_tape[i] !== exp_tape[i])
				report_value({name, " tape write"}, 256'(exp_tape[i]), 256'(got_tape[i]));
	end
	if (rom_map !== exp_map)
		report_value({name, " rom_map"}, exp_map, rom_map);
	mem_done  = exp_mem.size();
	tape_done = exp_tape.size();
endtask

task automatic test_rom_slots();
	logic [HOST_ADDR_W-1:0] a;
	logic [7:0]             d;
	open_file(IDX_ROM, 16'h0000, "rom_slots");
	for (int i = 0; i < 9; i++) begin
		a = HOST_ADDR_W'(i * 16384 + i * 111); // Slot i, small offset
		d = 8'($urandom);
		send_byte(a, d);
		expect_rom(a, d);
	end
	close_file("rom_slots");
	compare_writes("rom_slots");
	// BASIC and AMSDOS are the only high ROM pages
	if (rom_map !== 256'h81)
		report_value("rom_slots map", 256'h81, rom_map);
endtask

task automatic ext_file(input logic [15:0] ext, input string name, input int n,
	input logic [HOST_ADDR_W-1:0] a0, input logic [HOST_ADDR_W-1:0] a1,
	input logic [HOST_ADDR_W-1:0] a2);
	logic [HOST_ADDR_W-1:0] a;
	logic [7:0]             d;
	exp_page  = ext_first_page(ext);
	exp_combo = (ext == "Z0");
	open_file(IDX_EXT, ext, name);
	for (int i = 0; i < n; i++) begin
		a = (i == 0) ? a0 : (i == 1) ? a1 : a2;
		d = 8'($urandom);
		send_byte(a, d);
		expect_ext(a, d);
	end
	close_file(name);
	compare_writes(name);
endtask

task automatic test_ext_pages();
	ext_file("3A", "ext_3a", 2, 25'h0012, 25'h4034, 25'h0);
	ext_file("QQ", "ext_qq", 2, 25'h1000, 25'h7FFE, 25'h0);
	ext_file("ZZ", "ext_zz", 2, 25'h0001, 25'h4001, 25'h0);
endtask

// Page switch after the last byte of the first 16 KB
task automatic test_combo();
	ext_file("Z0", "combo", 3, 25'h0000, 25'h3FFF, 25'h4000);
endtask

task automatic test_tape();
	logic [HOST_ADDR_W-1:0] a;
	tape_wr_t               t;
	a = '0;
	open_file(IDX_TAPE, "CD", "tape");
	for (int i = 0; i < 24; i++) begin
		a      = HOST_ADDR_W'(32'h1F0 + i);
		t.addr = a[MEM_ADDR_W-1:0];
		t.data = 8'($urandom);
		send_byte(a, t.data);
		exp_tape.push_back(t);
	end
	close_file("tape");
	compare_writes("tape");
	if (tape_last_addr !== a[MEM_ADDR_W-1:0])
		report_value("tape last address", 256'(a[MEM_ADDR_W-1:0]), 256'(tape_last_addr));
endtask

task automatic test_reset_model();
	apply_reset(1'b0);
	repeat (3) @(posedge clk_sys);
	#1;
	if (sys_reset !== 1'b0 || dl_ready !== 1'b0)
		report_value("reset_model sys_reset/ready", 256'(0), 256'({sys_reset, dl_ready}));
	if (mem_wr_valid !== 1'b0 || tape_wr_valid !== 1'b0)
		report_value("reset_model valids", 256'(0), 256'({mem_wr_valid, tape_wr_valid}));
	if (rom_map !== '0)
		report_value("reset_model rom_map", 256'(0), rom_map);
	if (tape_last_addr !== '0)
		report_value("reset_model tape_last_addr", 256'(0), 256'(tape_last_addr));
	if (model !== 1'b0)
		report_value("reset_model model", 256'(0), 256'(model));
	cfg_cpc664 = 1'b1; // Machine running, model must hold
	repeat (4) @(posedge clk_sys);
	#1;
	if (model !== 1'b0)
		report_value("reset_model model held", 256'(0), 256'(model));
endtask

`endif

/* dv/loader_tb.sv */
////////////////////////////////////////
// Loader testbench with sinks and timeout
////////////////////////////////////////

`timescale 1ns/1ps

module loader_tb import loader_pkg::*; ();

	localparam int TOTAL_BYTES = 42;
	localparam int CYCLE_LIMIT = 8 * TOTAL_BYTES + 2000;

	logic                  clk_sys = 1'b0;
	logic                  reset, cfg_cpc664, dl_active, dl_valid, dl_ready;
	logic                  mem_wr_valid, tape_wr_valid, model, sys_reset;
	logic                  mem_wr_ready = 1'b0;
	logic                  tape_wr_ready = 1'b0;
	logic [7:0]            dl_index;
	logic [15:0]           dl_ext;
	host_byte_t            dl_byte;
	mem_wr_t               mem_wr;
	tape_wr_t              tape_wr;
	logic [ROM_MAP_W-1:0]  rom_map;
	logic [MEM_ADDR_W-1:0] tape_last_addr;
	mem_wr_t               got_mem[$], exp_mem[$];
	tape_wr_t              got_tape[$], exp_tape[$];
	logic [ROM_MAP_W-1:0]  exp_map;
	logic                  exp_model;
	int                    errors = 0;
	int                    cycles = 0;
	int                    mem_done = 0;  // Entries already compared
	int                    tape_done = 0;
	int                    seed_init;

	always #2 clk_sys = ~clk_sys;

	loader_top #(.MAP_PAGES(ROM_MAP_W)) dut (.*);

	// Sinks log at mid-cycle, where valid and ready are both settled
	always @(negedge clk_sys) begin
		if (mem_wr_valid && mem_wr_ready)
			got_mem.push_back(mem_wr);
		if (tape_wr_valid && tape_wr_ready)
			got_tape.push_back(tape_wr);
	end

	always @(posedge clk_sys) begin
		#1;
		mem_wr_ready  = ($urandom % 4) != 0;
		tape_wr_ready = ($urandom % 3) != 0; // Tape sink stalls more often
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic report_value(input string name, input logic [255:0] exp_val,
		input logic [255:0] act_val);
		errors++;
		$display("** Error %s: expected %0h, actual %0h", name, exp_val, act_val);
	endtask

	task automatic apply_reset(input logic cfg);
		@(posedge clk_sys);
		#1;
		reset      = 1'b1;
		cfg_cpc664 = cfg;
		repeat (8) @(posedge clk_sys);
		#1;
		if (sys_reset !== 1'b1)
			report_value("reset sys_reset", 256'(1), 256'(sys_reset));
		reset     = 1'b0;
		exp_map   = '0;
		exp_model = cfg;
	endtask

	task automatic open_file(input logic [7:0] idx, input logic [15:0] ext, input string name);
		logic hold;
		hold      = (idx == IDX_ROM || idx == IDX_EXT); // Machine kept in reset
		dl_index  = idx;
		dl_ext    = ext;
		dl_active = 1'b1;
		repeat (2) @(posedge clk_sys);
		#1;
		if (sys_reset !== hold)
			report_value({name, " sys_reset"}, 256'(hold), 256'(sys_reset));
	endtask

	// Valid stays high between bytes of one file
	task automatic send_byte(input logic [HOST_ADDR_W-1:0] addr, input logic [7:0] data);
		logic taken;
		taken        = 1'b0;
		dl_valid     = 1'b1;
		dl_byte.addr = addr;
		dl_byte.data = data;
		while (!taken) begin
			@(negedge clk_sys);
			taken = dl_ready;
			@(posedge clk_sys);
			#1;
		end
	endtask

	task automatic close_file(input string name);
		dl_valid  = 1'b0;
		dl_active = 1'b0;
		do begin
			@(negedge clk_sys);
		end while (mem_wr_valid || tape_wr_valid);
		repeat (2) @(posedge clk_sys);
		#1;
		if (sys_reset !== 1'b0)
			report_value({name, " idle sys_reset"}, 256'(0), 256'(sys_reset));
	endtask

	`include "loader_tests.svh"

	initial begin
		seed_init  = $urandom(58);
		reset      = 1'b1;
		cfg_cpc664 = 1'b1;
		dl_active  = 1'b0;
		dl_index   = 8'd0;
		dl_ext     = 16'd0;
		dl_valid   = 1'b0;
		dl_byte    = '0;
		apply_reset(1'b1);
		test_rom_slots();
		test_ext_pages();
		test_combo();
		test_tape();
		test_reset_model();
		$display("Closing report: %0d memory writes and %0d tape writes checked, %0d errors",
			mem_done, tape_done, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* list.f */
+incdir+dv
logic/loader_pkg.sv
logic/req_hold.sv
logic/rom_slot_map.sv
logic/ext_page_decode.sv
logic/loader_ctrl.sv
logic/loader_top.sv
dv/loader_tb.sv

/* logic/ext_page_decode.sv */
////////////////////////////////////////
// Expansion ROM page register, decoded from
// the file extension, with combo page switch
////////////////////////////////////////

`timescale 1ns/1ps

module ext_page_decode import loader_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   start,
	input  logic [15:0]            dl_ext,
	input  logic                   fire,
	input  logic [HOST_ADDR_W-1:0] host_addr,
	output logic [MEM_ADDR_W-1:0]  ext_addr
);

	logic [PAGE_W-1:0] page;
	logic              combo;        // OS+BASIC image, second half pending
	logic [PAGE_W-1:0] page_dec;
	logic              combo_dec;
	logic [4:0]        hi_nib;
	logic [4:0]        lo_nib;
	logic [7:0]        page_sum;

	// Upper-case hex character, bit 4 flags a valid digit
	function automatic logic [4:0] hex_nib(input logic [7:0] c);
		logic [4:0] r;
		r = 5'd0;
		if (c >= "0" && c <= "9")
			r = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			r = {1'b1, c[3:0] + 4'd9};
		return r;
	endfunction

	assign hi_nib = hex_nib(dl_ext[15:8]);
	assign lo_nib = hex_nib(dl_ext[7:0]);

	////////////////////////////////////////
	// Extension decode
	////////////////////////////////////////

	always_comb begin
		page_dec  = PAGE_BAD_EXT; // Malformed name lands on a spare page
		combo_dec = 1'b0;
		if (hi_nib[4])
			page_dec[7:4] = hi_nib[3:0];
		if (lo_nib[4])
			page_dec[3:0] = lo_nib[3:0];
		if (dl_ext == "ZZ")
			page_dec = '0;
		if (dl_ext == "Z0") begin
			page_dec  = '0;
			combo_dec = 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page  <= PAGE_BAD_EXT;
			combo <= 1'b0;
		end else if (start) begin
			page  <= page_dec;
			combo <= combo_dec;
		end else if (fire && combo && &host_addr[PAGE_OFS_W-1:0]) begin
			page  <= PAGE_COMBO_NEXT; // Last byte of first 16 KB
			combo <= 1'b0;
		end
	end

	// Page count wraps inside the high ROM half
	assign page_sum = page[7:0] + host_addr[21:14];
	assign ext_addr = {page[8], page_sum, host_addr[PAGE_OFS_W-1:0]};

endmodule

/* logic/loader_ctrl.sv */
////////////////////////////////////////
// Download classification, byte routing, reset
// request, model latch, ROM map, tape end
////////////////////////////////////////

`timescale 1ns/1ps

module loader_ctrl import loader_pkg::*; #(
	parameter int MAP_PAGES = ROM_MAP_W
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  cfg_cpc664,
	input  logic                  dl_active,
	input  logic [7:0]            dl_index,
	input  logic                  dl_valid,
	input  host_byte_t            dl_byte,
	output logic                  dl_ready,
	input  logic [MEM_ADDR_W-1:0] rom_addr,
	input  logic [1:0]            rom_bank,
	input  logic                  rom_slot_ok,
	input  logic [MEM_ADDR_W-1:0] ext_addr,
	output logic                  start,
	output logic                  fire,
	output logic                  mem_in_valid,
	output mem_wr_t               mem_in,
	input  logic                  mem_in_ready,
	output logic                  tape_in_valid,
	output tape_wr_t              tape_in,
	input  logic                  tape_in_ready,
	output logic [MAP_PAGES-1:0]  rom_map,
	output logic [MEM_ADDR_W-1:0] tape_last_addr,
	output logic                  model,
	output logic                  sys_reset
);

	dl_kind_t kind;
	logic     dl_active_q;
	logic     sel_ready;
	logic     accept;

	function automatic dl_kind_t classify(input logic [7:0] idx);
		dl_kind_t k;
		k = DL_NONE;
		if (idx == IDX_ROM)
			k = DL_ROM;
		else if (idx == IDX_EXT)
			k = DL_EXT;
		else if (idx == IDX_TAPE)
			k = DL_TAPE;
		return k;
	endfunction

	assign start = dl_active & ~dl_active_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			kind        <= DL_NONE;
		end else begin
			dl_active_q <= dl_active;
			if (!dl_active)
				kind <= DL_NONE;
			else if (start)
				kind <= classify(dl_index);
		end
	end

	////////////////////////////////////////
	// Byte acceptance and routing
	////////////////////////////////////////

	always_comb begin
		case (kind)
			DL_ROM:  sel_ready = rom_slot_ok ? mem_in_ready : 1'b1; // Surplus slots drop
			DL_EXT:  sel_ready = mem_in_ready;
			DL_TAPE: sel_ready = tape_in_ready;
			default: sel_ready = 1'b1;                              // Unknown index dropped
		endcase
	end

	// Held low on the start cycle while the kind settles
	assign dl_ready = dl_active & dl_active_q & sel_ready;
	assign accept   = dl_valid & dl_ready;
	assign fire     = accept & (kind == DL_EXT);

	assign mem_in_valid  = accept & ((kind == DL_ROM && rom_slot_ok) || kind == DL_EXT);
	assign tape_in_valid = accept & (kind == DL_TAPE);

	always_comb begin
		mem_in.addr = (kind == DL_EXT) ? ext_addr : rom_addr;
		mem_in.bank = (kind == DL_EXT) ? {1'b0, model} : rom_bank;
		mem_in.data = dl_byte.data;
	end

	assign tape_in.addr = dl_byte.addr[MEM_ADDR_W-1:0];
	assign tape_in.data = dl_byte.data;

	////////////////////////////////////////
	// Status
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_map        <= '0;
			tape_last_addr <= '0;
		end else begin
			if (mem_in_valid && mem_in.addr[22])
				rom_map[mem_in.addr[21:14]] <= 1'b1; // High ROM page now present
			if (tape_in_valid)
				tape_last_addr <= tape_in.addr;
		end
	end

	// Machine held in reset while ROM contents change
	always_ff @(posedge clk_sys) begin
		sys_reset <= reset | (dl_active & (dl_index == IDX_ROM || dl_index == IDX_EXT));
		if (sys_reset)
			model <= cfg_cpc664;
	end

	// Host keeps the index steady for the whole file
	a_index_stable: assert property (@(posedge clk_sys) disable iff (reset)
		dl_active && dl_active_q |-> $stable(dl_index));

endmodule

/* logic/loader_pkg.sv */
////////////////////////////////////////
// Shared widths, download kinds, slot base pages
// and request structs of the download loader
////////////////////////////////////////

package loader_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	localparam int HOST_ADDR_W = 25;  // Host byte address
	localparam int MEM_ADDR_W  = 23;  // 8 MB bank address
	localparam int PAGE_OFS_W  = 14;  // Offset inside a 16 KB page
	localparam int PAGE_W      = 9;   // Bit 8 picks the high ROM half
	localparam int ROM_MAP_W   = 256; // High ROM pages

	////////////////////////////////////////
	// Download indexes from the host
	////////////////////////////////////////

	localparam logic [7:0] IDX_ROM  = 8'd0;
	localparam logic [7:0] IDX_EXT  = 8'd3;
	localparam logic [7:0] IDX_TAPE = 8'd4;

	// System ROM slot bases
	localparam logic [PAGE_W-1:0] PAGE_OS     = 9'h000;
	localparam logic [PAGE_W-1:0] PAGE_BASIC  = 9'h100;
	localparam logic [PAGE_W-1:0] PAGE_AMSDOS = 9'h107;
	localparam logic [PAGE_W-1:0] PAGE_MF2    = 9'h0FF;

	// Spare page, never mapped by the system
	localparam logic [PAGE_W-1:0] PAGE_BAD_EXT    = 9'h1EE;
	// Second half of an OS+BASIC combo image
	localparam logic [PAGE_W-1:0] PAGE_COMBO_NEXT = 9'h1FF;

	typedef enum logic [1:0] {
		DL_NONE,
		DL_ROM,
		DL_EXT,
		DL_TAPE
	} dl_kind_t;

	////////////////////////////////////////
	// Byte streams
	////////////////////////////////////////

	typedef struct packed {
		logic [HOST_ADDR_W-1:0] addr;
		logic [7:0]             data;
	} host_byte_t;

	typedef struct packed {
		logic [MEM_ADDR_W-1:0] addr;
		logic [1:0]            bank; // 0 is CPC6128 set, 1 is CPC664 set
		logic [7:0]            data;
	} mem_wr_t;

	typedef struct packed {
		logic [MEM_ADDR_W-1:0] addr;
		logic [7:0]            data;
	} tape_wr_t;

endpackage

/* logic/loader_top.sv */
////////////////////////////////////////
// Download loader top level
////////////////////////////////////////

`timescale 1ns/1ps

module loader_top import loader_pkg::*; #(
	parameter int MAP_PAGES = ROM_MAP_W
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  cfg_cpc664,

	// Host byte stream
	input  logic                  dl_active,
	input  logic [7:0]            dl_index,
	input  logic [15:0]           dl_ext,
	input  logic                  dl_valid,
	input  host_byte_t            dl_byte,
	output logic                  dl_ready,

	// Memory and tape requests
	output logic                  mem_wr_valid,
	output mem_wr_t               mem_wr,
	input  logic                  mem_wr_ready,
	output logic                  tape_wr_valid,
	output tape_wr_t              tape_wr,
	input  logic                  tape_wr_ready,

	// Status to the machine
	output logic [MAP_PAGES-1:0]  rom_map,
	output logic [MEM_ADDR_W-1:0] tape_last_addr,
	output logic                  model,
	output logic                  sys_reset
);

	logic                  start;
	logic                  fire;
	logic [MEM_ADDR_W-1:0] rom_addr;
	logic [1:0]            rom_bank;
	logic                  rom_slot_ok;
	logic [MEM_ADDR_W-1:0] ext_addr;
	logic                  mem_in_valid;
	mem_wr_t               mem_in;
	logic                  mem_in_ready;
	logic                  tape_in_valid;
	tape_wr_t              tape_in;
	logic                  tape_in_ready;

	loader_ctrl #(
		.MAP_PAGES(MAP_PAGES)
	) ctrl (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.cfg_cpc664     (cfg_cpc664),
		.dl_active      (dl_active),
		.dl_index       (dl_index),
		.dl_valid       (dl_valid),
		.dl_byte        (dl_byte),
		.dl_ready       (dl_ready),
		.rom_addr       (rom_addr),
		.rom_bank       (rom_bank),
		.rom_slot_ok    (rom_slot_ok),
		.ext_addr       (ext_addr),
		.start          (start),
		.fire           (fire),
		.mem_in_valid   (mem_in_valid),
		.mem_in         (mem_in),
		.mem_in_ready   (mem_in_ready),
		.tape_in_valid  (tape_in_valid),
		.tape_in        (tape_in),
		.tape_in_ready  (tape_in_ready),
		.rom_map        (rom_map),
		.tape_last_addr (tape_last_addr),
		.model          (model),
		.sys_reset      (sys_reset)
	);

	rom_slot_map slot_map (
		.host_addr   (dl_byte.addr),
		.rom_addr    (rom_addr),
		.rom_bank    (rom_bank),
		.rom_slot_ok (rom_slot_ok)
	);

	ext_page_decode ext_page (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.start     (start),
		.dl_ext    (dl_ext),
		.fire      (fire),
		.host_addr (dl_byte.addr),
		.ext_addr  (ext_addr)
	);

	////////////////////////////////////////
	// Output holding registers
	////////////////////////////////////////

	req_hold #(.payload_t(mem_wr_t)) mem_hold (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.in_valid  (mem_in_valid),
		.in_data   (mem_in),
		.in_ready  (mem_in_ready),
		.out_valid (mem_wr_valid),
		.out_ready (mem_wr_ready),
		.out_data  (mem_wr)
	);

	req_hold #(.payload_t(tape_wr_t)) tape_hold (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.in_valid  (tape_in_valid),
		.in_data   (tape_in),
		.in_ready  (tape_in_ready),
		.out_valid (tape_wr_valid),
		.out_ready (tape_wr_ready),
		.out_data  (tape_wr)
	);

endmodule

/* logic/req_hold.sv */
////////////////////////////////////////
// One-entry valid/ready holding register
////////////////////////////////////////

`timescale 1ns/1ps

module req_hold #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     in_ready,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic full;

	// Room when empty or the current entry leaves this cycle
	assign in_ready  = ~full | out_ready;
	assign out_valid = full;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			full <= 1'b0;
		end else if (in_valid && in_ready) begin
			full <= 1'b1;
		end else if (out_ready) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (in_valid && in_ready)
			out_data <= in_data;
	end

	// A stalled request stays put until the sink takes it
	a_hold_stable: assert property (@(posedge clk_sys) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

/* logic/rom_slot_map.sv */
////////////////////////////////////////
// System ROM slot to page and bank decode
////////////////////////////////////////

`timescale 1ns/1ps

module rom_slot_map import loader_pkg::*; (
	input  logic [HOST_ADDR_W-1:0] host_addr,
	output logic [MEM_ADDR_W-1:0]  rom_addr,
	output logic [1:0]             rom_bank,
	output logic                   rom_slot_ok
);

	localparam int SLOT_W = HOST_ADDR_W - PAGE_OFS_W;

	logic [SLOT_W-1:0] slot;
	logic [PAGE_W-1:0] page;

	assign slot = host_addr[HOST_ADDR_W-1:PAGE_OFS_W]; // 16 KB slot number

	////////////////////////////////////////
	// Slot decode
	////////////////////////////////////////

	// Slots 0..3 and 4..7 hold the same four images, one set per model
	always_comb begin
		page        = '1;
		rom_slot_ok = 1'b1;
		case (slot)
			11'd0, 11'd4: page = PAGE_OS;
			11'd1, 11'd5: page = PAGE_BASIC;
			11'd2, 11'd6: page = PAGE_AMSDOS;
			11'd3, 11'd7: page = PAGE_MF2;
			default: begin
				rom_slot_ok = 1'b0; // Surplus slot, dropped
			end
		endcase
	end

	always_comb begin
		rom_bank = 2'd0;
		if (rom_slot_ok)
			rom_bank = {1'b0, slot[2]}; // Upper four slots go to bank 1
	end

	// Page base plus offset inside the page
	assign rom_addr = {page, host_addr[PAGE_OFS_W-1:0]};

endmodule

/* run.sh */
#!/bin/sh
# Build the loader testbench with Verilator, run it and check the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module loader_tb -f list.f -o loader_sim \
	|| { echo "Build failed"; exit 1; }
out=$(./obj_dir/loader_sim)
echo "$out"
echo "$out" | grep -qx "Verification passed" && exit 0 || exit 1
